// ==== verilog/c64_loader_pkg.sv ====
package c64_loader_pkg;

	// ==============================
	// Widths and basic types
	// ==============================

	localparam int addr_w = 25;

	typedef logic [7:0] byte_t;

	// Load address, either flat or split into 8 KB bank and offset
	typedef union packed {
		logic [addr_w-1:0] flat;
		struct packed {
			logic [11:0] bank;
			logic [12:0] offset;
		} bk;
	} load_addr_u;

	// ==============================
	// Download indices
	// ==============================

	localparam byte_t IDX_PRG = 8'd4;
	localparam byte_t IDX_CRT = 8'd5;
	localparam byte_t IDX_TAP = 8'd6;

	// ==============================
	// Memory map
	// ==============================

	// Cartridge banks start here, tape image further up
	localparam logic [addr_w-1:0] CART_BASE = 25'h100000;
	localparam logic [addr_w-1:0] TAP_BASE = 25'h200000;

	// First chip packet follows the 64-byte file header
	localparam logic [addr_w-1:0] CRT_CHIP_START = 25'h40;

endpackage

// ==== verilog/download_decoder.sv ====
`timescale 1ns/1ps

module download_decoder (
	input  logic clk_sys,
	input  logic reset_n,
	input  logic dl_active_i,
	input  c64_loader_pkg::byte_t dl_index_i,
	input  logic dl_wr_i,
	input  logic [c64_loader_pkg::addr_w-1:0] dl_addr_i,
	input  c64_loader_pkg::byte_t dl_data_i,
	output logic dl_wait_o,
	input  logic crt_payload_i,
	input  logic crt_align_i,
	input  logic write_done_i,
	output c64_loader_pkg::load_addr_u load_addr_o,
	output logic write_pend_o,
	output c64_loader_pkg::byte_t write_data_o
);

	import c64_loader_pkg::*;

	logic byte_wr;
	logic is_prg;
	logic is_crt;
	logic is_tap;

	assign byte_wr = dl_active_i & dl_wr_i;
	assign is_prg = (dl_index_i == IDX_PRG);
	assign is_crt = (dl_index_i == IDX_CRT);
	assign is_tap = (dl_index_i == IDX_TAP);

	// Host is held off while a byte waits for its slot
	assign dl_wait_o = write_pend_o;

	// ==============================
	// Load address and pending write
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr_o.flat <= '0;
			write_pend_o <= 1'b0;
		end else begin
			// Write went out in this slot, step to the next byte
			if (write_done_i) begin
				write_pend_o <= 1'b0;
				load_addr_o.flat <= load_addr_o.flat + 1'b1;
			end

			if (byte_wr) begin
				if (is_prg) begin
					// Two-byte load address comes first
					if (dl_addr_i == 25'd0) begin
						load_addr_o.flat <= {17'd0, dl_data_i};
					end else if (dl_addr_i == 25'd1) begin
						load_addr_o.flat[15:8] <= dl_data_i;
					end else begin
						write_pend_o <= 1'b1;
					end
				end

				if (is_crt) begin
					if (dl_addr_i == 25'd0) begin
						load_addr_o.flat <= CART_BASE;
					end else if (crt_align_i && load_addr_o.bk.offset != '0) begin
						// New chip packet, round up to the next 8 KB bank
						load_addr_o.bk.bank <= load_addr_o.bk.bank + 1'b1;
						load_addr_o.bk.offset <= '0;
					end
					if (crt_payload_i) begin
						write_pend_o <= 1'b1;
					end
				end

				if (is_tap) begin
					if (dl_addr_i == 25'd0) begin
						load_addr_o.flat <= TAP_BASE;
					end
					write_pend_o <= 1'b1;
				end
			end
		end
	end

	// Data of the byte waiting for a slot
	always_ff @(posedge clk_sys) begin
		if (byte_wr) begin
			write_data_o <= dl_data_i;
		end
	end

endmodule

// ==== verilog/crt_header_parser.sv ====
`timescale 1ns/1ps

module crt_header_parser (
	input  logic clk_sys,
	input  logic reset_n,
	input  c64_loader_pkg::byte_t dl_index_i,
	input  logic dl_wr_i,
	input  logic [c64_loader_pkg::addr_w-1:0] dl_addr_i,
	input  c64_loader_pkg::byte_t dl_data_i,
	input  logic dl_active_i,
	input  c64_loader_pkg::load_addr_u load_addr_i,
	input  logic cart_detach_i,
	output logic crt_payload_o,
	output logic crt_align_o,
	output logic [15:0] cart_id_o,
	output c64_loader_pkg::byte_t cart_exrom_o,
	output c64_loader_pkg::byte_t cart_game_o,
	output logic cart_attached_o,
	output logic bank_wr_o,
	output c64_loader_pkg::byte_t bank_type_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic [c64_loader_pkg::addr_w-1:0] bank_raddr_o
);

	import c64_loader_pkg::*;

	logic crt_dl;
	logic crt_byte;
	logic in_chips;
	logic [3:0] hdr_cnt;
	logic [31:0] blk_len;
	logic active_q;

	assign crt_dl = (dl_index_i == IDX_CRT);
	assign crt_byte = dl_active_i & dl_wr_i & crt_dl;
	assign in_chips = (dl_addr_i >= CRT_CHIP_START);

	// Nothing left of the last packet, so this byte opens a chip header
	assign crt_align_o = crt_byte & in_chips & (blk_len == '0) & (hdr_cnt == '0);
	assign crt_payload_o = crt_byte & in_chips & (blk_len != '0) & (hdr_cnt == '0);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt <= '0;
			blk_len <= '0;
			bank_wr_o <= 1'b0;
			cart_attached_o <= 1'b0;
			active_q <= 1'b0;
		end else begin
			bank_wr_o <= 1'b0;
			active_q <= dl_active_i;

			if (crt_byte) begin
				if (dl_addr_i == 25'd0) begin
					blk_len <= '0;
					hdr_cnt <= '0;
				end
				if (crt_align_o) begin
					hdr_cnt <= 4'd1;
				end else if (hdr_cnt != '0) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4'd4: blk_len[31:24] <= dl_data_i;
						4'd5: blk_len[23:16] <= dl_data_i;
						4'd6: blk_len[15:8] <= dl_data_i;
						4'd7: blk_len[7:0] <= dl_data_i;
						// Packet length covers its own 16-byte header
						4'd8: blk_len <= blk_len - 32'd16;
						4'd15: bank_wr_o <= 1'b1;
						default: ;
					endcase
				end else if (crt_payload_o) begin
					blk_len <= blk_len - 1'b1;
				end
			end

			// Attached once the cartridge download is complete
			if (crt_dl && active_q != dl_active_i) begin
				cart_attached_o <= active_q;
			end
			if (cart_detach_i) begin
				cart_attached_o <= 1'b0;
			end
		end
	end

	// ==============================
	// Header fields
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (crt_byte) begin
			if (dl_addr_i == 25'h16) cart_id_o[15:8] <= dl_data_i;
			if (dl_addr_i == 25'h17) cart_id_o[7:0] <= dl_data_i;
			if (dl_addr_i == 25'h18) cart_exrom_o <= dl_data_i;
			if (dl_addr_i == 25'h19) cart_game_o <= dl_data_i;
			case (hdr_cnt)
				4'd9: bank_type_o <= dl_data_i;
				4'd10: bank_num_o[15:8] <= dl_data_i;
				4'd11: bank_num_o[7:0] <= dl_data_i;
				4'd12: bank_laddr_o[15:8] <= dl_data_i;
				4'd13: bank_laddr_o[7:0] <= dl_data_i;
				4'd14: bank_size_o[15:8] <= dl_data_i;
				4'd15: begin
					bank_size_o[7:0] <= dl_data_i;
					// Address is already bank aligned here
					bank_raddr_o <= load_addr_i.flat;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== verilog/slot_arbiter.sv ====
`timescale 1ns/1ps

module slot_arbiter #(
	parameter int SLOT_PERIOD = 8
) (
	input  logic clk_sys,
	input  logic reset_n,
	input  logic write_pend_i,
	input  c64_loader_pkg::load_addr_u load_addr_i,
	input  c64_loader_pkg::byte_t write_data_i,
	output logic write_done_o,
	input  logic tape_req_i,
	input  logic [c64_loader_pkg::addr_w-1:0] tape_addr_i,
	output logic tape_grant_o,
	output logic mem_ce_o,
	output logic mem_we_o,
	output logic [c64_loader_pkg::addr_w-1:0] mem_addr_o,
	output c64_loader_pkg::byte_t mem_wdata_o
);

	import c64_loader_pkg::*;

	localparam int CNT_W = (SLOT_PERIOD > 1) ? $clog2(SLOT_PERIOD) : 1;

	logic [CNT_W-1:0] slot_cnt;
	logic slot_open;

	// Slot command is set up in the last cycle of the period
	assign slot_open = (slot_cnt == CNT_W'(SLOT_PERIOD - 1));

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_cnt <= '0;
		end else if (slot_open) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	// ==============================
	// Slot command
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
			write_done_o <= 1'b0;
			tape_grant_o <= 1'b0;
		end else if (slot_open) begin
			// Download write wins, tape gets the slot otherwise
			mem_ce_o <= write_pend_i | tape_req_i;
			mem_we_o <= write_pend_i;
			write_done_o <= write_pend_i;
			tape_grant_o <= ~write_pend_i & tape_req_i;
		end else begin
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
			write_done_o <= 1'b0;
			tape_grant_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_open) begin
			mem_addr_o <= write_pend_i ? load_addr_i.flat : tape_addr_i;
			mem_wdata_o <= write_data_i;
		end
	end

endmodule

// ==== verilog/tape_reader.sv ====
`timescale 1ns/1ps

module tape_reader #(
	parameter int TAPE_CREDITS = 4
) (
	input  logic clk_sys,
	input  logic reset_n,
	input  logic dl_active_i,
	input  c64_loader_pkg::byte_t dl_index_i,
	input  logic [c64_loader_pkg::addr_w-1:0] dl_addr_i,
	input  logic tape_play_btn_i,
	input  logic tape_unload_i,
	input  logic tape_credit_i,
	input  logic tape_grant_i,
	input  c64_loader_pkg::byte_t mem_rdata_i,
	output logic tape_req_o,
	output logic [c64_loader_pkg::addr_w-1:0] tape_addr_o,
	output logic tape_valid_o,
	output c64_loader_pkg::byte_t tape_byte_o
);

	import c64_loader_pkg::*;

	localparam int CRED_W = $clog2(TAPE_CREDITS + 1);

	logic tape_dl;
	logic btn_q;
	logic grant_q;
	logic playing;
	logic [addr_w-1:0] tape_len;
	logic [addr_w-1:0] play_addr;
	logic [CRED_W-1:0] credits;

	assign tape_dl = dl_active_i & (dl_index_i == IDX_TAP);

	// Read only with credit in hand and data left on the tape
	assign tape_req_o = playing & ~tape_dl & (credits != '0) & (play_addr < tape_len);
	assign tape_addr_o = TAP_BASE + play_addr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			btn_q <= 1'b0;
			grant_q <= 1'b0;
			tape_valid_o <= 1'b0;
			playing <= 1'b0;
			tape_len <= '0;
			play_addr <= '0;
			credits <= CRED_W'(TAPE_CREDITS);
		end else begin
			btn_q <= tape_play_btn_i;
			// Read data arrives the cycle after the slot
			grant_q <= tape_grant_i;
			tape_valid_o <= grant_q;

			if (tape_dl) begin
				// Restart while the image is loading, play once it is in
				tape_len <= dl_addr_i + 1'b1;
				play_addr <= '0;
				playing <= 1'b1;
				credits <= CRED_W'(TAPE_CREDITS);
			end else begin
				if (tape_play_btn_i && !btn_q) begin
					playing <= ~playing;
				end
				if (tape_unload_i) begin
					tape_len <= '0;
					playing <= 1'b0;
				end
				if (tape_grant_i) begin
					play_addr <= play_addr + 1'b1;
				end

				// One credit per read, one back per consumer pulse
				if (tape_grant_i && !tape_credit_i) begin
					credits <= credits - 1'b1;
				end else if (!tape_grant_i && tape_credit_i) begin
					credits <= credits + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (grant_q) begin
			tape_byte_o <= mem_rdata_i;
		end
	end

endmodule

// ==== verilog/c64_loader_top.sv ====
`timescale 1ns/1ps

module c64_loader_top #(
	parameter int SLOT_PERIOD = 8,
	parameter int TAPE_CREDITS = 4
) (
	input  logic clk_sys,
	input  logic reset_n,
	input  logic dl_active_i,
	input  c64_loader_pkg::byte_t dl_index_i,
	input  logic dl_wr_i,
	input  logic [c64_loader_pkg::addr_w-1:0] dl_addr_i,
	input  c64_loader_pkg::byte_t dl_data_i,
	output logic dl_wait_o,
	input  logic cart_detach_i,
	input  logic tape_play_btn_i,
	input  logic tape_unload_i,
	input  logic tape_credit_i,
	output logic tape_valid_o,
	output c64_loader_pkg::byte_t tape_byte_o,
	output logic mem_ce_o,
	output logic mem_we_o,
	output logic [c64_loader_pkg::addr_w-1:0] mem_addr_o,
	output c64_loader_pkg::byte_t mem_wdata_o,
	input  c64_loader_pkg::byte_t mem_rdata_i,
	output logic [15:0] cart_id_o,
	output c64_loader_pkg::byte_t cart_exrom_o,
	output c64_loader_pkg::byte_t cart_game_o,
	output logic cart_attached_o,
	output logic bank_wr_o,
	output c64_loader_pkg::byte_t bank_type_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic [c64_loader_pkg::addr_w-1:0] bank_raddr_o
);

	import c64_loader_pkg::*;

	load_addr_u load_addr;
	byte_t write_data;
	logic write_pend;
	logic write_done;
	logic crt_payload;
	logic crt_align;
	logic tape_req;
	logic tape_grant;
	logic [addr_w-1:0] tape_addr;

	download_decoder u_download_decoder (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i),
		.dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i),
		.dl_wait_o(dl_wait_o),
		.crt_payload_i(crt_payload),
		.crt_align_i(crt_align),
		.write_done_i(write_done),
		.load_addr_o(load_addr),
		.write_pend_o(write_pend),
		.write_data_o(write_data)
	);

	// Cartridge header registers sit next to the address they steer
	crt_header_parser u_crt_header_parser (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dl_index_i(dl_index_i),
		.dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i),
		.dl_active_i(dl_active_i),
		.load_addr_i(load_addr),
		.cart_detach_i(cart_detach_i),
		.crt_payload_o(crt_payload),
		.crt_align_o(crt_align),
		.cart_id_o(cart_id_o),
		.cart_exrom_o(cart_exrom_o),
		.cart_game_o(cart_game_o),
		.cart_attached_o(cart_attached_o),
		.bank_wr_o(bank_wr_o),
		.bank_type_o(bank_type_o),
		.bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o),
		.bank_size_o(bank_size_o),
		.bank_raddr_o(bank_raddr_o)
	);

	slot_arbiter #(
		.SLOT_PERIOD(SLOT_PERIOD)
	) u_slot_arbiter (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.write_pend_i(write_pend),
		.load_addr_i(load_addr),
		.write_data_i(write_data),
		.write_done_o(write_done),
		.tape_req_i(tape_req),
		.tape_addr_i(tape_addr),
		.tape_grant_o(tape_grant),
		.mem_ce_o(mem_ce_o),
		.mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o)
	);

	tape_reader #(
		.TAPE_CREDITS(TAPE_CREDITS)
	) u_tape_reader (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i),
		.dl_addr_i(dl_addr_i),
		.tape_play_btn_i(tape_play_btn_i),
		.tape_unload_i(tape_unload_i),
		.tape_credit_i(tape_credit_i),
		.tape_grant_i(tape_grant),
		.mem_rdata_i(mem_rdata_i),
		.tape_req_o(tape_req),
		.tape_addr_o(tape_addr),
		.tape_valid_o(tape_valid_o),
		.tape_byte_o(tape_byte_o)
	);

endmodule

// ==== bench/c64_loader_props.sv ====
`timescale 1ns/1ps

module c64_loader_props #(
	parameter int TAPE_CREDITS = 4
) (
	input  logic clk_sys,
	input  logic reset_n,
	input  logic dl_active_i,
	input  logic [7:0] dl_index_i,
	input  logic dl_wr_i,
	input  logic dl_wait_i,
	input  logic mem_ce_i,
	input  logic bank_wr_i,
	input  logic tape_credit_i,
	input  logic tape_valid_i
);

	import c64_loader_pkg::*;

	int fail_cnt = 0;
	int avail;

	// Credits still owed by the consumer, reloaded on every tape restart
	always_ff @(posedge clk_sys) begin
		if (!reset_n || (dl_active_i && dl_index_i == IDX_TAP)) begin
			avail <= TAPE_CREDITS;
		end else begin
			avail <= avail + int'(tape_credit_i) - int'(tape_valid_i);
		end
	end

	// ==============================
	// Handshake rules
	// ==============================

	ce_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_ce_i |=> !mem_ce_i)
		else begin
			fail_cnt++;
			$error("mem_ce_o held longer than one cycle");
		end

	tape_credit_ok: assert property (@(posedge clk_sys) disable iff (!reset_n)
		tape_valid_i |-> (avail > 0))
		else begin
			fail_cnt++;
			$error("tape byte sent without credit");
		end

	bank_wr_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_wr_i |=> !bank_wr_i)
		else begin
			fail_cnt++;
			$error("bank_wr_o longer than one cycle");
		end

	wait_vs_wr: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(dl_wait_i && dl_wr_i))
		else begin
			fail_cnt++;
			$error("host write while dl_wait_o is high");
		end

endmodule

bind c64_loader_top c64_loader_props #(
	.TAPE_CREDITS(TAPE_CREDITS)
) u_props (
	.clk_sys(clk_sys),
	.reset_n(reset_n),
	.dl_active_i(dl_active_i),
	.dl_index_i(dl_index_i),
	.dl_wr_i(dl_wr_i),
	.dl_wait_i(dl_wait_o),
	.mem_ce_i(mem_ce_o),
	.bank_wr_i(bank_wr_o),
	.tape_credit_i(tape_credit_i),
	.tape_valid_i(tape_valid_o)
);

// ==== bench/tb_c64_loader.sv ====
`timescale 1ns/1ps

module tb_c64_loader;

	import c64_loader_pkg::*;

	localparam int SLOT_PERIOD = 8;
	localparam int TAPE_CREDITS = 4;
	localparam int MAX_CYCLES = 20000;

	logic clk_sys;
	logic reset_n;
	logic dl_active_i;
	logic [7:0] dl_index_i;
	logic dl_wr_i;
	logic [24:0] dl_addr_i;
	logic [7:0] dl_data_i;
	logic dl_wait_o;
	logic cart_detach_i;
	logic tape_play_btn_i;
	logic tape_unload_i;
	logic tape_credit_i;
	logic tape_valid_o;
	logic [7:0] tape_byte_o;
	logic mem_ce_o;
	logic mem_we_o;
	logic [24:0] mem_addr_o;
	logic [7:0] mem_wdata_o;
	logic [7:0] mem_rdata_i;
	logic [15:0] cart_id_o;
	logic [7:0] cart_exrom_o;
	logic [7:0] cart_game_o;
	logic cart_attached_o;
	logic bank_wr_o;
	logic [7:0] bank_type_o;
	logic [15:0] bank_num_o;
	logic [15:0] bank_laddr_o;
	logic [15:0] bank_size_o;
	logic [24:0] bank_raddr_o;

	logic [7:0] mem [int];
	logic [7:0] rx_q [$];
	logic [7:0] exp_q [$];
	logic [7:0] crt_q [$];
	logic [7:0] bw_type [$];
	logic [15:0] bw_num [$];
	logic [15:0] bw_laddr [$];
	logic [15:0] bw_size [$];
	logic [24:0] bw_raddr [$];
	logic [7:0] prg [16];
	int errors;
	int cycles;
	int credit_owed;
	int caddr;
	int n;
	int base2;
	bit auto_credit;
	integer seed;

	c64_loader_top #(
		.SLOT_PERIOD(SLOT_PERIOD),
		.TAPE_CREDITS(TAPE_CREDITS)
	) u_c64_loader_top (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i),
		.dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i),
		.dl_wait_o(dl_wait_o),
		.cart_detach_i(cart_detach_i),
		.tape_play_btn_i(tape_play_btn_i),
		.tape_unload_i(tape_unload_i),
		.tape_credit_i(tape_credit_i),
		.tape_valid_o(tape_valid_o),
		.tape_byte_o(tape_byte_o),
		.mem_ce_o(mem_ce_o),
		.mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o),
		.mem_rdata_i(mem_rdata_i),
		.cart_id_o(cart_id_o),
		.cart_exrom_o(cart_exrom_o),
		.cart_game_o(cart_game_o),
		.cart_attached_o(cart_attached_o),
		.bank_wr_o(bank_wr_o),
		.bank_type_o(bank_type_o),
		.bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o),
		.bank_size_o(bank_size_o),
		.bank_raddr_o(bank_raddr_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ==============================
	// Memory model and monitors
	// ==============================

	// Unwritten locations read back a pattern of the full address
	function automatic logic [7:0] read_mem(input int a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return 8'(a ^ (a >> 8) ^ (a >> 16) ^ (a >> 24)) ^ 8'h5a;
	endfunction

	always @(posedge clk_sys) begin
		if (mem_ce_o) begin
			if (mem_we_o) begin
				mem[int'(mem_addr_o)] = mem_wdata_o;
			end else begin
				mem_rdata_i <= read_mem(int'(mem_addr_o));
			end
		end
	end

	always @(negedge clk_sys) begin
		if (tape_valid_o) begin
			rx_q.push_back(tape_byte_o);
			credit_owed++;
		end
		if (bank_wr_o) begin
			bw_type.push_back(bank_type_o);
			bw_num.push_back(bank_num_o);
			bw_laddr.push_back(bank_laddr_o);
			bw_size.push_back(bank_size_o);
			bw_raddr.push_back(bank_raddr_o);
		end
	end

	// Consumer hands back one credit per received byte when enabled
	initial begin
		forever begin
			@(posedge clk_sys);
			#1;
			if (auto_credit && credit_owed > 0) begin
				tape_credit_i = 1'b1;
				credit_owed--;
			end else begin
				tape_credit_i = 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ==============================
	// Helper tasks
	// ==============================

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else begin
			errors++;
			$display("** Error [%0t] %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic idle(input int cnt);
		repeat (cnt) @(posedge clk_sys);
		#1;
	endtask

	task automatic dl_start(input logic [7:0] idx);
		dl_index_i = idx;
		dl_active_i = 1'b1;
		idle(1);
	endtask

	task automatic dl_end();
		dl_active_i = 1'b0;
		idle(2);
	endtask

	// One host byte, then hold off until its write is committed
	task automatic dl_byte(input int addr, input logic [7:0] d);
		dl_addr_i = 25'(addr);
		dl_data_i = d;
		dl_wr_i = 1'b1;
		idle(1);
		dl_wr_i = 1'b0;
		while (dl_wait_o) idle(1);
	endtask

	task automatic send_chip(input logic [7:0] ctype, input logic [15:0] bank,
		input logic [15:0] laddr, input int plen);
		logic [31:0] len;
		logic [15:0] size;
		logic [7:0] hdr [16];
		logic [7:0] d;
		len = 32'(plen + 16);
		size = 16'(plen);
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50, len[31:24], len[23:16], len[15:8], len[7:0],
			8'h00, ctype, bank[15:8], bank[7:0], laddr[15:8], laddr[7:0], size[15:8], size[7:0]};
		for (int j = 0; j < 16; j++) begin
			dl_byte(caddr + j, hdr[j]);
		end
		caddr += 16;
		for (int j = 0; j < plen; j++) begin
			d = 8'($random(seed));
			crt_q.push_back(d);
			dl_byte(caddr, d);
			caddr++;
		end
	endtask

	task automatic load_tape(input int cnt);
		logic [7:0] d;
		exp_q.delete();
		dl_start(IDX_TAP);
		for (int i = 0; i < cnt; i++) begin
			d = 8'($random(seed));
			exp_q.push_back(d);
			dl_byte(i, d);
		end
		dl_end();
		for (int i = 0; i < cnt; i++) begin
			check_val(read_mem(int'(TAP_BASE) + i), exp_q[i], "tape byte in memory");
		end
	endtask

	task automatic wait_rx(input int cnt);
		while (rx_q.size() < cnt) @(posedge clk_sys);
		#1;
	endtask

	task automatic check_stream();
		for (int i = 0; i < rx_q.size(); i++) begin
			check_val(rx_q[i], exp_q[i], "tape stream byte");
		end
	endtask

	task automatic press_play();
		tape_play_btn_i = 1'b1;
		idle(1);
		tape_play_btn_i = 1'b0;
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		seed = 52;
		errors = 0;
		credit_owed = 0;
		auto_credit = 1'b1;
		reset_n = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i = 8'd0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = 8'd0;
		cart_detach_i = 1'b0;
		tape_play_btn_i = 1'b0;
		tape_unload_i = 1'b0;
		tape_credit_i = 1'b0;
		mem_rdata_i = 8'd0;
		idle(4);
		reset_n = 1'b1;
		check_val({mem_ce_o, mem_we_o, dl_wait_o, tape_valid_o, bank_wr_o, cart_attached_o},
			0, "outputs after reset");

		// Program file at 0801
		dl_start(IDX_PRG);
		dl_byte(0, 8'h01);
		dl_byte(1, 8'h08);
		for (int i = 0; i < 16; i++) begin
			prg[i] = 8'($random(seed));
			dl_byte(i + 2, prg[i]);
		end
		dl_end();
		for (int i = 0; i < 16; i++) begin
			check_val(read_mem(32'h801 + i), prg[i], "program byte");
		end

		// Cartridge with two chip packets
		dl_start(IDX_CRT);
		for (int a = 0; a < 64; a++) begin
			case (a)
				'h16: dl_byte(a, 8'h00);
				'h17: dl_byte(a, 8'h13);
				'h18: dl_byte(a, 8'h01);
				'h19: dl_byte(a, 8'h00);
				default: dl_byte(a, 8'(a));
			endcase
		end
		check_val(cart_attached_o, 0, "attached during download");
		caddr = 64;
		send_chip(8'h02, 16'h0000, 16'h8000, 16);
		send_chip(8'h01, 16'h0001, 16'ha000, 8);
		dl_end();
		check_val(cart_id_o, 16'h0013, "cartridge id");
		check_val(cart_exrom_o, 8'h01, "exrom");
		check_val(cart_game_o, 8'h00, "game");
		check_val(cart_attached_o, 1, "attached after download");
		check_val(bw_type.size(), 2, "bank_wr pulse count");
		// Second packet starts on the next 8 KB bank after the first payload
		base2 = ((int'(CART_BASE) + 16 + 8191) / 8192) * 8192;
		if (bw_type.size() == 2) begin
			check_val(bw_type[0], 8'h02, "bank type 0");
			check_val(bw_num[0], 16'h0000, "bank num 0");
			check_val(bw_laddr[0], 16'h8000, "bank laddr 0");
			check_val(bw_size[0], 16'd16, "bank size 0");
			check_val(bw_raddr[0], CART_BASE, "bank raddr 0");
			check_val(bw_type[1], 8'h01, "bank type 1");
			check_val(bw_num[1], 16'h0001, "bank num 1");
			check_val(bw_laddr[1], 16'ha000, "bank laddr 1");
			check_val(bw_size[1], 16'd8, "bank size 1");
			check_val(bw_raddr[1], 25'(base2), "bank raddr 1");
		end
		for (int j = 0; j < 16; j++) begin
			check_val(read_mem(int'(CART_BASE) + j), crt_q[j], "cart payload 0");
		end
		for (int j = 0; j < 8; j++) begin
			check_val(read_mem(base2 + j), crt_q[16 + j], "cart payload 1");
		end
		cart_detach_i = 1'b1;
		idle(1);
		cart_detach_i = 1'b0;
		idle(1);
		check_val(cart_attached_o, 0, "attached after detach");

		// Tape load and full playback
		rx_q.delete();
		load_tape(12);
		wait_rx(12);
		idle(SLOT_PERIOD * 4);
		check_val(rx_q.size(), 12, "tape byte count");
		check_stream();

		// Back-pressure, then release
		auto_credit = 1'b0;
		credit_owed = 0;
		rx_q.delete();
		load_tape(10);
		wait_rx(TAPE_CREDITS);
		idle(SLOT_PERIOD * 12);
		check_val(rx_q.size(), TAPE_CREDITS, "bytes without credit return");
		auto_credit = 1'b1;
		wait_rx(10);
		idle(SLOT_PERIOD * 4);
		check_val(rx_q.size(), 10, "bytes after credit return");
		check_stream();

		// Pause, resume, unload
		rx_q.delete();
		load_tape(20);
		wait_rx(5);
		press_play();
		idle(4);
		n = rx_q.size();
		idle(SLOT_PERIOD * 10);
		check_val(rx_q.size(), n, "stream while paused");
		press_play();
		wait_rx(n + 3);
		tape_unload_i = 1'b1;
		idle(1);
		tape_unload_i = 1'b0;
		idle(4);
		n = rx_q.size();
		idle(SLOT_PERIOD * 10);
		check_val(rx_q.size(), n, "stream after unload");
		// Play again finds an empty tape
		press_play();
		idle(SLOT_PERIOD * 10);
		check_val(rx_q.size(), n, "stream after play on unloaded tape");
		check_stream();

		$display("Run complete: %0d check errors, %0d assertion failures",
			errors, u_c64_loader_top.u_props.fail_cnt);
		if (errors == 0 && u_c64_loader_top.u_props.fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
verilog/c64_loader_pkg.sv
verilog/download_decoder.sv
verilog/crt_header_parser.sv
verilog/slot_arbiter.sv
verilog/tape_reader.sv
verilog/c64_loader_top.sv
bench/c64_loader_props.sv
bench/tb_c64_loader.sv

// ==== Makefile ====
TOP = tb_c64_loader
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
